//--- Makefile
# Verilator simulation of the link training state machine

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module ltsm_tb -f sim.f
	@out="$$(./obj_dir/Vltsm_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- sim.f
verilog/ltsm_state_pkg.sv
verilog/ltsm_timing_pkg.sv
verilog/ltsm_ctrl_if.sv
verilog/ltsm_state_ctrl.sv
verilog/ltsm_timers.sv
verilog/ltsm_top.sv
sim/ltsm_tb.sv

//--- sim/ltsm_tb.sv
`timescale 1ns/10ps

module ltsm_tb;

    localparam int unsigned RESET_DWELL_CYCLES   = 20;
    localparam int unsigned STATE_TIMEOUT_CYCLES = 60;
    localparam int unsigned RETRY_CYCLES         = 16;

    logic                        clk_100MHz;
    logic                        reset;
    logic                        enable_i;
    logic                        start_lt_i;
    ltsm_state_pkg::phase_vec_t  phase_done_i;
    ltsm_state_pkg::phase_vec_t  timeout_clear_i;
    ltsm_state_pkg::phase_vec_t  retry_clear_i;
    ltsm_state_pkg::ltsm_state_t state_o;
    ltsm_state_pkg::phase_vec_t  phase_enable_o;
    logic                        active_o;
    logic                        retry_timeout_o;

    logic [31:0]                 lfsr;

    ltsm_top #(
        .RESET_DWELL_CYCLES   (RESET_DWELL_CYCLES),
        .STATE_TIMEOUT_CYCLES (STATE_TIMEOUT_CYCLES),
        .RETRY_CYCLES         (RETRY_CYCLES)
    ) i_dut (
        .clk_100MHz      (clk_100MHz),
        .reset           (reset),
        .enable_i        (enable_i),
        .start_lt_i      (start_lt_i),
        .phase_done_i    (phase_done_i),
        .timeout_clear_i (timeout_clear_i),
        .retry_clear_i   (retry_clear_i),
        .state_o         (state_o),
        .phase_enable_o  (phase_enable_o),
        .active_o        (active_o),
        .retry_timeout_o (retry_timeout_o)
    );

    initial begin
        clk_100MHz = 1'b0;
        forever #5 clk_100MHz = ~clk_100MHz;
    end

    // Phase vector bit owned by each training state
    function automatic ltsm_state_pkg::phase_vec_t enable_for(
        input ltsm_state_pkg::ltsm_state_t st);
        case (st)
            ltsm_state_pkg::SBINIT:     return 6'b000001;
            ltsm_state_pkg::MBINIT:     return 6'b000010;
            ltsm_state_pkg::MBTRAIN:    return 6'b000100;
            ltsm_state_pkg::LINKINIT:   return 6'b001000;
            ltsm_state_pkg::ACTIVE:     return 6'b010000;
            ltsm_state_pkg::TRAINERROR: return 6'b100000;
            default:                    return 6'b000000;
        endcase
    endfunction

    // Where a done of the current phase leads
    function automatic ltsm_state_pkg::ltsm_state_t next_of(
        input ltsm_state_pkg::ltsm_state_t st);
        case (st)
            ltsm_state_pkg::SBINIT:     return ltsm_state_pkg::MBINIT;
            ltsm_state_pkg::MBINIT:     return ltsm_state_pkg::MBTRAIN;
            ltsm_state_pkg::MBTRAIN:    return ltsm_state_pkg::LINKINIT;
            ltsm_state_pkg::LINKINIT:   return ltsm_state_pkg::ACTIVE;
            ltsm_state_pkg::TRAINERROR: return ltsm_state_pkg::RESET;
            default:                    return st;
        endcase
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_random(input int unsigned nbits, output logic [31:0] value);
        int unsigned i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        stop_with_failure($sformatf("** Error: %s expected 0x%0h, actual 0x%0h",
                                    name, expected, actual));
    endtask

    task automatic expect_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual == expected)
            else value_mismatch(name, expected, actual);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_100MHz);
        #1;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) next_cycle();
        reset = 1'b0;
    endtask

    task automatic wait_for_state(input ltsm_state_pkg::ltsm_state_t target,
                                  input int unsigned limit, output int unsigned edges);
        edges = 0;
        while (state_o != target) begin
            if (edges == limit) begin
                stop_with_failure($sformatf("Timed out after %0d cycles waiting for state %s",
                                            limit, target.name()));
            end else begin
                next_cycle();
                edges++;
            end
        end
    endtask

    // Low cycles between two consecutive retry pulses
    task automatic measure_retry_gap(output int unsigned low_cycles);
        int unsigned waited;
        waited     = 0;
        low_cycles = 0;
        next_cycle();
        while (!retry_timeout_o) begin
            if (waited == 2 * RETRY_CYCLES) begin
                stop_with_failure("No retry timeout pulse arrived");
            end else begin
                next_cycle();
                waited++;
            end
        end
        next_cycle();
        while (!retry_timeout_o) begin
            if (low_cycles == 2 * RETRY_CYCLES) begin
                stop_with_failure("Second retry timeout pulse never arrived");
            end else begin
                next_cycle();
                low_cycles++;
            end
        end
    endtask

    task automatic pulse_done(input ltsm_state_pkg::ltsm_state_t st);
        phase_done_i = enable_for(st);
        next_cycle();
        phase_done_i = '0;
    endtask

    assert property (@(posedge clk_100MHz) disable iff (reset)
        phase_enable_o == enable_for(state_o))
        else value_mismatch("phase_enable_o", 32'(enable_for(state_o)), 32'(phase_enable_o));

    assert property (@(posedge clk_100MHz) disable iff (reset)
        active_o == (state_o == ltsm_state_pkg::ACTIVE))
        else value_mismatch("active_o", 32'(state_o == ltsm_state_pkg::ACTIVE), 32'(active_o));

    // Done of the current phase steps the state on the next edge
    assert property (@(posedge clk_100MHz) disable iff (reset)
        (state_o inside {ltsm_state_pkg::SBINIT, ltsm_state_pkg::MBINIT,
                         ltsm_state_pkg::MBTRAIN, ltsm_state_pkg::LINKINIT,
                         ltsm_state_pkg::TRAINERROR})
        && ((phase_done_i & enable_for(state_o)) != '0)
        |=> state_o == next_of($past(state_o)))
        else value_mismatch("state_o", 32'(next_of($past(state_o))), 32'(state_o));

    // Stray done bits leave a training phase alone
    assert property (@(posedge clk_100MHz) disable iff (reset)
        (state_o inside {ltsm_state_pkg::SBINIT, ltsm_state_pkg::MBINIT,
                         ltsm_state_pkg::MBTRAIN, ltsm_state_pkg::LINKINIT})
        && ((phase_done_i & enable_for(state_o)) == '0)
        |=> (state_o == $past(state_o)) || (state_o == ltsm_state_pkg::TRAINERROR))
        else value_mismatch("state_o", 32'($past(state_o)), 32'(state_o));

    assert property (@(posedge clk_100MHz) disable iff (reset)
        state_o == ltsm_state_pkg::ACTIVE
        |=> state_o inside {ltsm_state_pkg::ACTIVE, ltsm_state_pkg::TRAINERROR})
        else value_mismatch("state_o", 32'(ltsm_state_pkg::ACTIVE), 32'(state_o));

    assert property (@(posedge clk_100MHz) disable iff (reset)
        (state_o == ltsm_state_pkg::RESET) && !(enable_i && start_lt_i)
        |=> state_o == ltsm_state_pkg::RESET)
        else value_mismatch("state_o", 32'(ltsm_state_pkg::RESET), 32'(state_o));

    // A timeout clear of the current phase holds off TRAINERROR
    assert property (@(posedge clk_100MHz) disable iff (reset)
        (state_o != ltsm_state_pkg::TRAINERROR)
        && ((timeout_clear_i & enable_for(state_o)) != '0)
        |=> state_o != ltsm_state_pkg::TRAINERROR)
        else value_mismatch("state_o", 32'($past(state_o)), 32'(state_o));

    assert property (@(posedge clk_100MHz) disable iff (reset)
        state_o == ltsm_state_pkg::RESET |-> !retry_timeout_o)
        else value_mismatch("retry_timeout_o", 32'h0, 32'(retry_timeout_o));

    assert property (@(posedge clk_100MHz) disable iff (reset)
        (retry_clear_i & enable_for(state_o)) != '0 |-> !retry_timeout_o)
        else value_mismatch("retry_timeout_o", 32'h0, 32'(retry_timeout_o));

    initial begin
        int unsigned                 edges;
        int unsigned                 low_cycles;
        logic [31:0]                 rnd;
        logic [31:0]                 gap;
        ltsm_state_pkg::ltsm_state_t st;

        lfsr            = 32'hc77e4973;
        reset           = 1'b1;
        enable_i        = 1'b0;
        start_lt_i      = 1'b1;
        phase_done_i    = '0;
        timeout_clear_i = '0;
        retry_clear_i   = '0;

        // Reset values, then start gated off by either input
        apply_reset();
        expect_value("state_o", 32'(ltsm_state_pkg::RESET), 32'(state_o));
        expect_value("phase_enable_o", 32'h0, 32'(phase_enable_o));
        expect_value("active_o", 32'h0, 32'(active_o));
        expect_value("retry_timeout_o", 32'h0, 32'(retry_timeout_o));
        repeat (3 * RESET_DWELL_CYCLES) next_cycle();
        enable_i   = 1'b1;
        start_lt_i = 1'b0;
        repeat (3 * RESET_DWELL_CYCLES) next_cycle();
        expect_value("state_o", 32'(ltsm_state_pkg::RESET), 32'(state_o));

        // Dwell count from reset release, dwell_done closes cycle D
        start_lt_i = 1'b1;
        apply_reset();
        wait_for_state(ltsm_state_pkg::SBINIT, 2 * RESET_DWELL_CYCLES, edges);
        expect_value("state_o cycles to SBINIT", RESET_DWELL_CYCLES, edges);

        // Retry pulses in SBINIT, timeout held off meanwhile
        timeout_clear_i = enable_for(ltsm_state_pkg::SBINIT);
        repeat (3) begin
            measure_retry_gap(low_cycles);
            expect_value("retry_timeout_o low cycles", RETRY_CYCLES - 1, low_cycles);
        end
        retry_clear_i = enable_for(ltsm_state_pkg::SBINIT);
        repeat (3 * RETRY_CYCLES) next_cycle();
        retry_clear_i = enable_for(ltsm_state_pkg::MBTRAIN);
        measure_retry_gap(low_cycles);
        expect_value("retry_timeout_o low cycles", RETRY_CYCLES - 1, low_cycles);
        retry_clear_i   = '0;
        timeout_clear_i = '0;

        // Walk up to ACTIVE with random gaps and stray done bits
        st = ltsm_state_pkg::SBINIT;
        repeat (4) begin
            take_random(3, gap);
            repeat (gap[2:0]) begin
                take_random(6, rnd);
                phase_done_i = rnd[5:0] & ~enable_for(st);
                next_cycle();
            end
            pulse_done(st);
            wait_for_state(next_of(st), 1, edges);
            st = next_of(st);
        end
        repeat (8) begin
            take_random(6, rnd);
            phase_done_i = rnd[5:0];
            next_cycle();
        end
        phase_done_i = '0;
        expect_value("active_o", 32'h1, 32'(active_o));

        // ACTIVE only leaves on a timeout
        wait_for_state(ltsm_state_pkg::TRAINERROR, STATE_TIMEOUT_CYCLES + 2, edges);
        pulse_done(ltsm_state_pkg::TRAINERROR);
        wait_for_state(ltsm_state_pkg::RESET, 1, edges);

        // MBINIT timeout with no clear
        wait_for_state(ltsm_state_pkg::SBINIT, 2 * RESET_DWELL_CYCLES, edges);
        pulse_done(ltsm_state_pkg::SBINIT);
        wait_for_state(ltsm_state_pkg::TRAINERROR, 2 * STATE_TIMEOUT_CYCLES, edges);
        expect_value("state_o cycles to TRAINERROR", STATE_TIMEOUT_CYCLES, edges);
        pulse_done(ltsm_state_pkg::TRAINERROR);
        wait_for_state(ltsm_state_pkg::RESET, 1, edges);

        // Second pass, clear keeps MBINIT alive
        wait_for_state(ltsm_state_pkg::SBINIT, 2 * RESET_DWELL_CYCLES, edges);
        pulse_done(ltsm_state_pkg::SBINIT);
        timeout_clear_i = enable_for(ltsm_state_pkg::MBINIT);
        repeat (3 * STATE_TIMEOUT_CYCLES) next_cycle();
        expect_value("state_o", 32'(ltsm_state_pkg::MBINIT), 32'(state_o));
        timeout_clear_i = '0;
        wait_for_state(ltsm_state_pkg::TRAINERROR, 2 * STATE_TIMEOUT_CYCLES, edges);
        expect_value("state_o cycles to TRAINERROR", STATE_TIMEOUT_CYCLES, edges);
        pulse_done(ltsm_state_pkg::TRAINERROR);
        wait_for_state(ltsm_state_pkg::RESET, 1, edges);

        repeat (4) next_cycle();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- verilog/ltsm_ctrl_if.sv
`timescale 1ns/10ps

interface ltsm_ctrl_if;

    // Driven by the state controller
    ltsm_state_pkg::ltsm_state_t state;
    logic                        state_change;
    logic                        next_is_error;

    // Driven by the timer block, single cycle pulses
    logic                        dwell_done;
    logic                        state_timeout;

    modport ctrl (
        output state,
        output state_change,
        output next_is_error,
        input  dwell_done,
        input  state_timeout
    );

    modport timers (
        input  state,
        input  state_change,
        input  next_is_error,
        output dwell_done,
        output state_timeout
    );

endinterface

//--- verilog/ltsm_state_ctrl.sv
`timescale 1ns/10ps

module ltsm_state_ctrl (
    input  logic                        clk_100MHz,
    input  logic                        reset,
    input  logic                        enable_i,
    input  logic                        start_lt_i,
    input  ltsm_state_pkg::phase_vec_t  phase_done_i,
    ltsm_ctrl_if.ctrl                   ctrl,
    output ltsm_state_pkg::ltsm_state_t state_o,
    output ltsm_state_pkg::phase_vec_t  phase_enable_o,
    output logic                        active_o
);

    ltsm_state_pkg::ltsm_state_t state_q;
    ltsm_state_pkg::ltsm_state_t state_next;
    ltsm_state_pkg::phase_vec_t  phase_en;
    logic                        cur_done;
    logic                        take_error;

    // One-hot enable of the phase handler that owns the current state
    always_comb begin
        phase_en = '0;
        case (state_q)
            ltsm_state_pkg::SBINIT: begin
                phase_en[ltsm_state_pkg::PH_SBINIT] = 1'b1;
            end
            ltsm_state_pkg::MBINIT: begin
                phase_en[ltsm_state_pkg::PH_MBINIT] = 1'b1;
            end
            ltsm_state_pkg::MBTRAIN: begin
                phase_en[ltsm_state_pkg::PH_MBTRAIN] = 1'b1;
            end
            ltsm_state_pkg::LINKINIT: begin
                phase_en[ltsm_state_pkg::PH_LINKINIT] = 1'b1;
            end
            ltsm_state_pkg::ACTIVE: begin
                phase_en[ltsm_state_pkg::PH_ACTIVE] = 1'b1;
            end
            ltsm_state_pkg::TRAINERROR: begin
                phase_en[ltsm_state_pkg::PH_TRAINERROR] = 1'b1;
            end
            default: begin
                phase_en = '0;
            end
        endcase
    end

    // Only the done bit of the enabled phase counts
    assign cur_done = |(phase_done_i & phase_en);

    // Next state, timeout wins over everything else
    always_comb begin
        state_next = state_q;
        take_error = 1'b0;
        if (ctrl.state_timeout) begin
            state_next = ltsm_state_pkg::TRAINERROR;
            take_error = 1'b1;
        end else begin
            case (state_q)
                ltsm_state_pkg::RESET: begin
                    if (enable_i && start_lt_i && ctrl.dwell_done) begin
                        state_next = ltsm_state_pkg::SBINIT;
                    end
                end
                ltsm_state_pkg::SBINIT: begin
                    if (cur_done) begin
                        state_next = ltsm_state_pkg::MBINIT;
                    end
                end
                ltsm_state_pkg::MBINIT: begin
                    if (cur_done) begin
                        state_next = ltsm_state_pkg::MBTRAIN;
                    end
                end
                ltsm_state_pkg::MBTRAIN: begin
                    if (cur_done) begin
                        state_next = ltsm_state_pkg::LINKINIT;
                    end
                end
                ltsm_state_pkg::LINKINIT: begin
                    if (cur_done) begin
                        state_next = ltsm_state_pkg::ACTIVE;
                    end
                end
                // Link stays up until a timeout
                ltsm_state_pkg::ACTIVE: begin
                    state_next = ltsm_state_pkg::ACTIVE;
                end
                ltsm_state_pkg::TRAINERROR: begin
                    if (cur_done) begin
                        state_next = ltsm_state_pkg::RESET;
                    end
                end
                default: begin
                    state_next = ltsm_state_pkg::RESET;
                end
            endcase
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            state_q <= ltsm_state_pkg::RESET;
        end else begin
            state_q <= state_next;
        end
    end

    // Events for the timer block
    assign ctrl.state         = state_q;
    assign ctrl.state_change  = (state_next != state_q);
    assign ctrl.next_is_error = take_error;

    assign state_o        = state_q;
    assign phase_enable_o = phase_en;
    assign active_o       = (state_q == ltsm_state_pkg::ACTIVE);

endmodule

//--- verilog/ltsm_state_pkg.sv
package ltsm_state_pkg;

    // One bit per training phase in the phase vectors
    localparam int unsigned NUM_PHASES = 6;

    // Training state encoding
    // Code 6 is unused and falls back to RESET
    typedef enum logic [2:0] {
        RESET      = 3'd0,
        SBINIT     = 3'd1,
        MBINIT     = 3'd2,
        MBTRAIN    = 3'd3,
        LINKINIT   = 3'd4,
        ACTIVE     = 3'd5,
        TRAINERROR = 3'd7
    } ltsm_state_t;

    // Bit position of each phase in a phase vector
    typedef enum logic [2:0] {
        PH_SBINIT     = 3'd0,
        PH_MBINIT     = 3'd1,
        PH_MBTRAIN    = 3'd2,
        PH_LINKINIT   = 3'd3,
        PH_ACTIVE     = 3'd4,
        PH_TRAINERROR = 3'd5
    } phase_idx_t;

    typedef logic [NUM_PHASES-1:0] phase_vec_t;

endpackage

//--- verilog/ltsm_timers.sv
`timescale 1ns/10ps

module ltsm_timers #(
    parameter int unsigned RESET_DWELL_CYCLES   = ltsm_timing_pkg::RESET_DWELL_CYCLES_DEF,
    parameter int unsigned STATE_TIMEOUT_CYCLES = ltsm_timing_pkg::STATE_TIMEOUT_CYCLES_DEF,
    parameter int unsigned RETRY_CYCLES         = ltsm_timing_pkg::RETRY_CYCLES_DEF
) (
    input  logic                       clk_100MHz,
    input  logic                       reset,
    input  ltsm_state_pkg::phase_vec_t timeout_clear_i,
    input  ltsm_state_pkg::phase_vec_t retry_clear_i,
    ltsm_ctrl_if.timers                timers,
    output logic                       retry_timeout_o
);

    // Counter widths, at least one bit each
    localparam int unsigned DWELL_W = (RESET_DWELL_CYCLES > 1) ? $clog2(RESET_DWELL_CYCLES) : 1;
    localparam int unsigned TMO_W   = (STATE_TIMEOUT_CYCLES > 1) ? $clog2(STATE_TIMEOUT_CYCLES) : 1;
    localparam int unsigned RETRY_W = (RETRY_CYCLES > 1) ? $clog2(RETRY_CYCLES) : 1;

    typedef logic [DWELL_W-1:0] dwell_cnt_t;
    typedef logic [TMO_W-1:0]   tmo_cnt_t;
    typedef logic [RETRY_W-1:0] retry_cnt_t;

    localparam dwell_cnt_t DWELL_LAST = dwell_cnt_t'(RESET_DWELL_CYCLES - 1);
    localparam tmo_cnt_t   TMO_LAST   = tmo_cnt_t'(STATE_TIMEOUT_CYCLES - 1);
    localparam retry_cnt_t RETRY_LAST = retry_cnt_t'(RETRY_CYCLES - 1);

    dwell_cnt_t dwell_cnt;
    tmo_cnt_t   tmo_cnt;
    retry_cnt_t retry_cnt;
    logic       in_reset;
    logic       tmo_clear;
    logic       retry_clear;
    logic       retry_hit;

    // Pick the request bit of the phase that owns the current state
    function automatic logic phase_bit(input ltsm_state_pkg::ltsm_state_t st,
                                       input ltsm_state_pkg::phase_vec_t  vec);
        logic sel;
        sel = 1'b0;
        case (st)
            ltsm_state_pkg::SBINIT:     sel = vec[ltsm_state_pkg::PH_SBINIT];
            ltsm_state_pkg::MBINIT:     sel = vec[ltsm_state_pkg::PH_MBINIT];
            ltsm_state_pkg::MBTRAIN:    sel = vec[ltsm_state_pkg::PH_MBTRAIN];
            ltsm_state_pkg::LINKINIT:   sel = vec[ltsm_state_pkg::PH_LINKINIT];
            ltsm_state_pkg::ACTIVE:     sel = vec[ltsm_state_pkg::PH_ACTIVE];
            ltsm_state_pkg::TRAINERROR: sel = vec[ltsm_state_pkg::PH_TRAINERROR];
            default:                    sel = 1'b0;
        endcase
        return sel;
    endfunction

    assign in_reset    = (timers.state == ltsm_state_pkg::RESET);
    assign tmo_clear   = in_reset || phase_bit(timers.state, timeout_clear_i);
    assign retry_clear = in_reset || phase_bit(timers.state, retry_clear_i);

    // Reset dwell, runs only while in RESET
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            dwell_cnt <= '0;
        end else if (!in_reset || dwell_cnt == DWELL_LAST) begin
            dwell_cnt <= '0;
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    assign timers.dwell_done = in_reset && (dwell_cnt == DWELL_LAST);

    // State timeout
    // Restarts on every state change and on a repeat timeout in TRAINERROR
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            tmo_cnt <= '0;
        end else if (tmo_clear || timers.state_change || timers.next_is_error) begin
            tmo_cnt <= '0;
        end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    // A clear in the terminal cycle still holds off the error
    assign timers.state_timeout = (tmo_cnt == TMO_LAST) && !tmo_clear;

    // Sideband message retry window, free running between clears
    assign retry_hit = (retry_cnt == RETRY_LAST);

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            retry_cnt <= '0;
        end else if (retry_clear || retry_hit) begin
            retry_cnt <= '0;
        end else begin
            retry_cnt <= retry_cnt + 1'b1;
        end
    end

    assign retry_timeout_o = retry_hit && !retry_clear;

endmodule

//--- verilog/ltsm_timing_pkg.sv
package ltsm_timing_pkg;

    // Timer defaults in cycles of the 100 MHz clock

    // Shortened reset dwell for simulation
    // The full 4 ms dwell is 400000 cycles
    localparam int unsigned RESET_DWELL_CYCLES_DEF = 100;

    // 8 ms state timeout
    localparam int unsigned STATE_TIMEOUT_CYCLES_DEF = 800000;

    // 1 us sideband message retry window
    localparam int unsigned RETRY_CYCLES_DEF = 100;

endpackage

//--- verilog/ltsm_top.sv
`timescale 1ns/10ps

module ltsm_top #(
    parameter int unsigned RESET_DWELL_CYCLES   = ltsm_timing_pkg::RESET_DWELL_CYCLES_DEF,
    parameter int unsigned STATE_TIMEOUT_CYCLES = ltsm_timing_pkg::STATE_TIMEOUT_CYCLES_DEF,
    parameter int unsigned RETRY_CYCLES         = ltsm_timing_pkg::RETRY_CYCLES_DEF
) (
    input  logic                        clk_100MHz,
    input  logic                        reset,
    input  logic                        enable_i,
    input  logic                        start_lt_i,

    // From the external phase handlers
    input  ltsm_state_pkg::phase_vec_t  phase_done_i,
    input  ltsm_state_pkg::phase_vec_t  timeout_clear_i,
    input  ltsm_state_pkg::phase_vec_t  retry_clear_i,

    output ltsm_state_pkg::ltsm_state_t state_o,
    output ltsm_state_pkg::phase_vec_t  phase_enable_o,
    output logic                        active_o,
    output logic                        retry_timeout_o
);

    // State and timer events between controller and timers
    ltsm_ctrl_if i_ctrl_if ();

    ltsm_state_ctrl i_state_ctrl (
        .clk_100MHz     (clk_100MHz),
        .reset          (reset),
        .enable_i       (enable_i),
        .start_lt_i     (start_lt_i),
        .phase_done_i   (phase_done_i),
        .ctrl           (i_ctrl_if.ctrl),
        .state_o        (state_o),
        .phase_enable_o (phase_enable_o),
        .active_o       (active_o)
    );

    ltsm_timers #(
        .RESET_DWELL_CYCLES   (RESET_DWELL_CYCLES),
        .STATE_TIMEOUT_CYCLES (STATE_TIMEOUT_CYCLES),
        .RETRY_CYCLES         (RETRY_CYCLES)
    ) i_timers (
        .clk_100MHz      (clk_100MHz),
        .reset           (reset),
        .timeout_clear_i (timeout_clear_i),
        .retry_clear_i   (retry_clear_i),
        .timers          (i_ctrl_if.timers),
        .retry_timeout_o (retry_timeout_o)
    );

endmodule
